//--- sources.f
+incdir+logic
+incdir+testbench
logic/msx_pkg.sv
logic/addr_demux.sv
logic/slot_select.sv
logic/config_regs.sv
logic/mapper_regs.sv
logic/bus_isolation.sv
logic/msx_bridge_top.sv
testbench/tb_msx_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and search the log for the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -f sources.f --top-module tb_msx_bridge -o tb_msx_bridge \
    && ./obj_dir/tb_msx_bridge | tee sim.log \
    || echo "build or simulation step failed"

grep -qx "TEST OK" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- testbench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------------------------------------
// reference model of the bridge
// --------------------------------------------------
// two select bits per 16k page, page 0 lowest
function automatic msx_pkg::slot_t page_slot(input msx_pkg::bus_byte_t sel,
                                             input msx_pkg::cpu_addr_t a);
    case (a[15:14])
        2'd0: return sel[1:0];
        2'd1: return sel[3:2];
        2'd2: return sel[5:4];
        default: return sel[7:6];
    endcase
endfunction

function automatic logic mapper_hit(input msx_pkg::cpu_addr_t a);
    return (page_slot(m_ppi, a) == m_map_slot) &&
           ((m_m0_en && page_slot(m_exp, a) == 2'd3 && a != 16'hFFFF) || m_m123_en);
endfunction

function automatic msx_pkg::mapper_addr_t mapper_addr(input msx_pkg::cpu_addr_t a);
    return {m_pages[a[15:14]], a[13:0]};
endfunction

// read data priority: mapper, ffff register, config, slot 0, external bus
function automatic msx_pkg::bus_byte_t expected_din(input logic is_io,
                                                    input msx_pkg::cpu_addr_t a);
    if (is_io) begin
        if (a[7:4] != 4'h4) return ext_data;
        return (a[3:0] == 4'h0) ? m_cfg0 : (a[3:0] == 4'h1) ? m_cfg1 : 8'hFF;
    end
    if (mapper_hit(a)) return mem_rdata;
    if (page_slot(m_ppi, a) == 2'd0) return (a == 16'hFFFF) ? ~m_exp : 8'hFF;
    return ext_data;
endfunction

task automatic model_write(input logic is_io, input msx_pkg::cpu_addr_t a,
                           input msx_pkg::bus_byte_t d);
    if (!is_io) begin
        if (a == 16'hFFFF && page_slot(m_ppi, a) == 2'd0) m_exp = d;
    end else if (a[7:0] == 8'hA8) begin
        m_ppi = d;
    end else if (a[7:2] == 6'h3F) begin
        m_pages[a[1:0]] = d;
    end else if (a[7:0] == 8'h40) begin
        m_cfg0 = ~d;
    end else if (m_cfg0 == 8'hB7 && a[7:0] == 8'h41) begin
        m_cfg1 = d;
    end else if (m_cfg0 == 8'hB7 && a[7:0] == 8'h42 && d[7]) begin
        // apply the mapper fields of config1
        m_map_slot = m_cfg1[5:4];
        m_m0_en    = m_cfg1[0] && (m_cfg1[5:4] == 2'd0);
        m_m123_en  = m_cfg1[0] && (m_cfg1[5:4] != 2'd0);
    end
endtask

// --------------------------------------------------
// compare tasks
// --------------------------------------------------
task automatic compare_byte(input string name, input msx_pkg::bus_byte_t got,
                            input msx_pkg::bus_byte_t exp);
    if (got !== exp) begin
        $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        err_byte++;
    end
endtask

task automatic compare_addr(input string name, input msx_pkg::mapper_addr_t got,
                            input msx_pkg::mapper_addr_t exp);
    if (got !== exp) begin
        $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        err_addr++;
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        err_bit++;
    end
endtask

`endif

//--- testbench/tb_msx_bridge.sv
`timescale 1ns/10ps
`default_nettype none
`include "msx_config.svh"

module tb_msx_bridge;

    localparam int CLK_PERIOD   = 20;
    localparam int HOLD_CYCLES  = 12;
    localparam int NUM_DEMUX    = 4;
    localparam int NUM_RANDOM   = 6;
    localparam int NUM_ACCESSES = 16 + 4 * NUM_RANDOM;
    localparam int DEMUX_CLKS   = 4 * (`MSX_DEMUX_TON + `MSX_DEMUX_TP) + 8;
    // twice the expected run length
    localparam int WATCHDOG_NS  = 2 * CLK_PERIOD *
        (8 + NUM_DEMUX * (DEMUX_CLKS + 4) + NUM_ACCESSES * (HOLD_CYCLES + 2));
    localparam logic IO  = 1'b1;
    localparam logic MEM = 1'b0;
    localparam logic WR  = 1'b1;
    localparam logic RD  = 1'b0;

    logic                  clk_108m;
    logic                  bus_reset_n;
    msx_pkg::cpu_addr_t    addr;
    msx_pkg::bus_byte_t    cpu_dout;
    logic                  m1_n;
    logic                  mreq_n;
    logic                  iorq_n;
    logic                  rd_n;
    logic                  wr_n;
    logic                  rfsh_n;
    logic                  update_addr;
    msx_pkg::bus_byte_t    ext_data;
    msx_pkg::bus_byte_t    mem_rdata;
    msx_pkg::bus_byte_t    cpu_din;
    logic [1:0]            msel;
    msx_pkg::bus_byte_t    bus_mp;
    logic                  ext_mreq_n;
    logic                  ext_iorq_n;
    logic                  ext_rd_n;
    logic                  ext_wr_n;
    logic                  data_drive;
    msx_pkg::mapper_addr_t mem_addr;
    logic                  mem_read;
    logic                  mem_write;

    // reference model state
    msx_pkg::bus_byte_t    m_ppi;
    msx_pkg::bus_byte_t    m_exp;
    msx_pkg::bus_byte_t    m_pages [4];
    msx_pkg::bus_byte_t    m_cfg0;
    msx_pkg::bus_byte_t    m_cfg1;
    msx_pkg::slot_t        m_map_slot;
    logic                  m_m0_en;
    logic                  m_m123_en;

    integer                seed = 32'ha7fee25a;
    int                    err_byte = 0;
    int                    err_addr = 0;
    int                    err_bit = 0;
    int                    err_other = 0;
    msx_pkg::cpu_addr_t    demux_addr = 16'h0000;
    msx_pkg::bus_byte_t    exp_din = 8'h00;
    logic                  din_check_en = 1'b0;

`include "tb_checks.svh"

    msx_bridge_top i_msx_bridge_top (.*);

    initial begin
        clk_108m = 1'b0;
        forever #(CLK_PERIOD / 2) clk_108m = ~clk_108m;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    // demux byte order and cpu read data
    always @(negedge clk_108m) begin
        if (msel == 2'b11) begin
            $display("both address strobes high at %0t", $time);
            err_other++;
        end
        if (msel[1]) compare_byte("bus_mp", bus_mp, demux_addr[15:8]);
        if (msel[0]) compare_byte("bus_mp", bus_mp, demux_addr[7:0]);
        if (din_check_en) compare_byte("cpu_din", cpu_din, exp_din);
    end

    // --------------------------------------------------
    // stimulus tasks
    // --------------------------------------------------
    task automatic demux_run(input msx_pkg::cpu_addr_t a);
        int   wait_clks;
        logic seen_lo;
        logic done;
        wait_clks = 0;
        seen_lo   = 1'b0;
        done      = 1'b0;
        @(negedge clk_108m);
        addr       = a;
        demux_addr = a;
        @(negedge clk_108m);
        update_addr = 1'b1;
        // done once the low byte strobe has come and gone
        while (!done && wait_clks < DEMUX_CLKS) begin
            @(negedge clk_108m);
            wait_clks++;
            if (msel[0]) seen_lo = 1'b1;
            else if (seen_lo) done = 1'b1;
        end
        if (!done) begin
            $display("address demux never finished the low byte strobe for %h", a);
            err_other++;
        end
        update_addr = 1'b0;
        repeat (2) @(negedge clk_108m);
    endtask

    task automatic bus_cycle(input logic is_io, input logic is_wr,
                             input msx_pkg::cpu_addr_t a, input msx_pkg::bus_byte_t d);
        logic [31:0] rnd;
        logic        hit;
        logic        internal;
        string       strobe_name;
        string       mem_name;
        rnd = $random(seed);
        strobe_name = is_wr ? "ext_wr_n" : "ext_rd_n";
        mem_name    = is_wr ? "mem_write" : "mem_read";
        // address goes out a cycle ahead of the strobes
        @(negedge clk_108m);
        addr      = a;
        cpu_dout  = d;
        ext_data  = rnd[7:0];
        mem_rdata = rnd[15:8];
        hit       = !is_io && mapper_hit(a);
        internal  = is_io ? (!is_wr && a[7:4] == 4'h4) : (page_slot(m_ppi, a) == 2'd0 || hit);
        @(negedge clk_108m);
        mreq_n = is_io;
        iorq_n = !is_io;
        rd_n   = is_wr;
        wr_n   = !is_wr;
        @(negedge clk_108m);
        compare_bit(strobe_name, is_wr ? ext_wr_n : ext_rd_n, 1'b1);
        repeat (HOLD_CYCLES - 3) @(negedge clk_108m);
        exp_din      = expected_din(is_io, a);
        din_check_en = !is_wr;
        compare_bit(strobe_name, is_wr ? ext_wr_n : ext_rd_n, internal);
        compare_bit("data_drive", data_drive, is_wr && !internal);
        if (is_io) begin
            compare_bit("ext_iorq_n", ext_iorq_n, internal);
        end else begin
            compare_bit("ext_mreq_n", ext_mreq_n, internal);
            compare_bit(mem_name, is_wr ? mem_write : mem_read, hit);
            if (hit) compare_addr("mem_addr", mem_addr, mapper_addr(a));
        end
        repeat (2) @(negedge clk_108m);
        din_check_en = 1'b0;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        if (is_wr) model_write(is_io, a, d);
        @(negedge clk_108m);
        compare_bit(strobe_name, is_wr ? ext_wr_n : ext_rd_n, 1'b1);
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] rnd;
        int          i;
        bus_reset_n = 1'b0;
        addr        = 16'h0000;
        cpu_dout    = 8'h00;
        m1_n        = 1'b1;
        mreq_n      = 1'b1;
        iorq_n      = 1'b1;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        rfsh_n      = 1'b1;
        update_addr = 1'b0;
        ext_data    = 8'h00;
        mem_rdata   = 8'h00;
        m_ppi       = 8'h00;
        m_exp       = 8'h00;
        m_pages     = '{8'h03, 8'h02, 8'h01, 8'h00};
        m_cfg0      = 8'h00;
        m_cfg1      = 8'h0B;
        m_map_slot  = 2'd0;
        m_m0_en     = 1'b1;
        m_m123_en   = 1'b0;
        repeat (8) @(negedge clk_108m);
        bus_reset_n = 1'b1;

        for (i = 0; i < NUM_DEMUX; i++) begin
            rnd = $random(seed);
            demux_run(rnd[15:0]);
        end

        // slot 0 everywhere, page 0 on sub-slot 0
        bus_cycle(IO, WR, 16'h00A8, 8'h00);
        rnd = $random(seed);
        bus_cycle(MEM, WR, 16'hFFFF, {rnd[7:2], 2'b00});
        bus_cycle(MEM, RD, 16'hFFFF, 8'h00);
        bus_cycle(MEM, RD, {2'b00, rnd[29:16]}, 8'h00);

        // mapper behind sub-slot 3, reset pages first
        bus_cycle(MEM, WR, 16'hFFFF, 8'hFF);
        for (i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            bus_cycle(MEM, RD, rnd[15:0], 8'h00);
        end
        for (i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            bus_cycle(IO, WR, {8'h00, 6'h3F, rnd[1:0]}, rnd[15:8]);
        end
        for (i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            bus_cycle(MEM, RD, rnd[15:0], 8'h00);
        end
        rnd = $random(seed);
        bus_cycle(MEM, WR, rnd[15:0], rnd[23:16]);

        // config1 locked until the key is in config0
        rnd = $random(seed);
        bus_cycle(IO, WR, 16'h0041, 8'h31);
        bus_cycle(IO, RD, 16'h0041, 8'h00);
        bus_cycle(IO, WR, 16'h0040, 8'h48);
        bus_cycle(IO, RD, 16'h0040, 8'h00);
        bus_cycle(IO, WR, 16'h0041, {rnd[7:6], 2'b00, rnd[3:1], 1'b0});
        bus_cycle(IO, RD, 16'h0041, 8'h00);
        bus_cycle(IO, WR, 16'h0042, 8'h80);
        bus_cycle(MEM, RD, {2'b00, rnd[29:16]}, 8'h00);

        // all pages on slot 1, the external bus
        bus_cycle(IO, WR, 16'h00A8, 8'h55);
        for (i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            bus_cycle(MEM, RD, rnd[15:0], 8'h00);
        end
        rnd = $random(seed);
        bus_cycle(MEM, WR, rnd[15:0], rnd[23:16]);

        repeat (2) @(negedge clk_108m);
        $display("errors: byte %0d, address %0d, bit %0d, other %0d",
                 err_byte, err_addr, err_bit, err_other);
        if (err_byte + err_addr + err_bit + err_other == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/msx_bridge_top.sv
`timescale 1ns/10ps
`default_nettype none

module msx_bridge_top (
    input  wire                     clk_108m,
    input  wire                     bus_reset_n,
    // z80 bus
    input  wire msx_pkg::cpu_addr_t addr,
    input  wire msx_pkg::bus_byte_t cpu_dout,
    input  wire                     m1_n,
    input  wire                     mreq_n,
    input  wire                     iorq_n,
    input  wire                     rd_n,
    input  wire                     wr_n,
    input  wire                     rfsh_n,
    input  wire                     update_addr,
    output msx_pkg::bus_byte_t      cpu_din,
    // cartridge slot side
    input  wire msx_pkg::bus_byte_t ext_data,
    output logic [1:0]              msel,
    output msx_pkg::bus_byte_t      bus_mp,
    output logic                    ext_mreq_n,
    output logic                    ext_iorq_n,
    output logic                    ext_rd_n,
    output logic                    ext_wr_n,
    output logic                    data_drive,
    // memory port
    input  wire msx_pkg::bus_byte_t mem_rdata,
    output msx_pkg::mapper_addr_t   mem_addr,
    output logic                    mem_read,
    output logic                    mem_write
);

    msx_pkg::slot_t     pri_slot;
    msx_pkg::onehot4_t  pri_slot_num;
    msx_pkg::onehot4_t  exp_slot3_num;
    msx_pkg::bus_byte_t exp_slot3_reg;
    logic               xffff;
    logic               cfg_read;
    msx_pkg::bus_byte_t cfg_dout;
    msx_pkg::slot_t     mapper_slot;
    logic               mapper0_en;
    logic               mapper123_en;

    addr_demux i_addr_demux (
        .clk_108m, .bus_reset_n, .addr, .update_addr,
        .msel, .bus_mp
    );

    slot_select i_slot_select (
        .clk_108m, .bus_reset_n, .addr, .cpu_dout,
        .m1_n, .mreq_n, .iorq_n, .wr_n,
        .pri_slot, .pri_slot_num, .exp_slot3_num, .exp_slot3_reg, .xffff
    );

    config_regs i_config_regs (
        .clk_108m, .bus_reset_n, .addr, .cpu_dout,
        .m1_n, .iorq_n, .rd_n, .wr_n,
        .cfg_read, .cfg_dout, .mapper_slot, .mapper0_en, .mapper123_en
    );

    mapper_regs i_mapper_regs (
        .clk_108m, .bus_reset_n, .addr, .cpu_dout,
        .m1_n, .mreq_n, .iorq_n, .rd_n, .wr_n, .rfsh_n,
        .pri_slot, .exp_slot3_num, .xffff,
        .mapper_slot, .mapper0_en, .mapper123_en,
        .mem_addr, .mem_read, .mem_write
    );

    // strobe gating and cpu read-data mux
    bus_isolation i_bus_isolation (
        .clk_108m, .bus_reset_n,
        .mreq_n, .iorq_n, .rd_n, .wr_n,
        .xffff, .pri_slot_num, .mem_read, .mem_write, .mem_rdata,
        .cfg_read, .cfg_dout, .exp_slot3_reg, .ext_data,
        .ext_mreq_n, .ext_iorq_n, .ext_rd_n, .ext_wr_n,
        .data_drive, .cpu_din
    );

endmodule

`default_nettype wire

//--- logic/bus_isolation.sv
`timescale 1ns/10ps
`default_nettype none
`include "msx_config.svh"

module bus_isolation (
    input  wire                     clk_108m,
    input  wire                     bus_reset_n,
    input  wire                     mreq_n,
    input  wire                     iorq_n,
    input  wire                     rd_n,
    input  wire                     wr_n,
    input  wire                     xffff,
    input  wire msx_pkg::onehot4_t  pri_slot_num,
    input  wire                     mem_read,
    input  wire                     mem_write,
    input  wire msx_pkg::bus_byte_t mem_rdata,
    input  wire                     cfg_read,
    input  wire msx_pkg::bus_byte_t cfg_dout,
    input  wire msx_pkg::bus_byte_t exp_slot3_reg,
    input  wire msx_pkg::bus_byte_t ext_data,
    output logic                    ext_mreq_n,
    output logic                    ext_iorq_n,
    output logic                    ext_rd_n,
    output logic                    ext_wr_n,
    output logic                    data_drive,
    output msx_pkg::bus_byte_t      cpu_din
);

    msx_pkg::iso_state_t state;
    logic [2:0]          count;
    logic                rd_dly_n;
    logic                wr_dly_n;
    logic                slot0_rd;
    logic                exp_rd;
    logic                mreq_disable;
    logic                iorq_disable;

    // --------------------------------------------------
    // internal targets
    // --------------------------------------------------
    assign slot0_rd     = !mreq_n && !rd_n && pri_slot_num[0];
    assign exp_rd       = slot0_rd && xffff;
    assign mreq_disable = (!mreq_n && pri_slot_num[0]) || mem_read || mem_write;
    assign iorq_disable = cfg_read;

    assign ext_mreq_n = mreq_n | mreq_disable;
    assign ext_iorq_n = iorq_n | iorq_disable;
    assign ext_rd_n   = rd_n | rd_dly_n | mreq_disable | iorq_disable;
    assign ext_wr_n   = wr_n | wr_dly_n | mreq_disable | iorq_disable;
    assign data_drive = !wr_n && !mreq_disable;

    assign cpu_din = mem_read ? mem_rdata :
                     exp_rd   ? ~exp_slot3_reg :
                     cfg_read ? cfg_dout :
                     slot0_rd ? 8'hFF : ext_data;

    // --------------------------------------------------
    // rd/wr delay so the address settles on the slot bus
    // --------------------------------------------------
    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            state    <= msx_pkg::ISO_IDLE;
            count    <= 3'd0;
            rd_dly_n <= 1'b1;
            wr_dly_n <= 1'b1;
        end else begin
            case (state)
                msx_pkg::ISO_IDLE: begin
                    count    <= 3'd0;
                    rd_dly_n <= 1'b1;
                    wr_dly_n <= 1'b1;
                    if (!rd_n || !wr_n) begin
                        state <= msx_pkg::ISO_ACTIVE;
                    end
                end
                msx_pkg::ISO_ACTIVE: begin
                    count <= count + 3'd1;
                    if (count == `MSX_ISO_DELAY) begin
                        rd_dly_n <= rd_n;
                        wr_dly_n <= wr_n;
                        state    <= msx_pkg::ISO_WAIT;
                    end
                end
                msx_pkg::ISO_WAIT: begin
                    if (rd_n && wr_n) begin
                        rd_dly_n <= 1'b1;
                        wr_dly_n <= 1'b1;
                        state    <= msx_pkg::ISO_IDLE;
                    end
                end
                default: state <= msx_pkg::ISO_IDLE;
            endcase
        end
    end

    a_ext_rw_exclusive: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        ext_rd_n || ext_wr_n);

endmodule

`default_nettype wire

//--- logic/mapper_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "msx_config.svh"

module mapper_regs (
    input  wire                     clk_108m,
    input  wire                     bus_reset_n,
    input  wire msx_pkg::cpu_addr_t addr,
    input  wire msx_pkg::bus_byte_t cpu_dout,
    input  wire                     m1_n,
    input  wire                     mreq_n,
    input  wire                     iorq_n,
    input  wire                     rd_n,
    input  wire                     wr_n,
    input  wire                     rfsh_n,
    input  wire msx_pkg::slot_t     pri_slot,
    input  wire msx_pkg::onehot4_t  exp_slot3_num,
    input  wire                     xffff,
    input  wire msx_pkg::slot_t     mapper_slot,
    input  wire                     mapper0_en,
    input  wire                     mapper123_en,
    output msx_pkg::mapper_addr_t   mem_addr,
    output logic                    mem_read,
    output logic                    mem_write
);

    msx_pkg::bus_byte_t page_reg [4];
    logic               reg_wr;
    logic               hit;

    assign reg_wr = !iorq_n && m1_n && !wr_n && (addr[7:2] == `MSX_PORT_MAPPER_BASE);

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            page_reg[0] <= `MSX_MAPPER_RESET0;
            page_reg[1] <= `MSX_MAPPER_RESET1;
            page_reg[2] <= `MSX_MAPPER_RESET2;
            page_reg[3] <= `MSX_MAPPER_RESET3;
        end else if (reg_wr) begin
            page_reg[addr[1:0]] <= cpu_dout;
        end
    end

    assign mem_addr = {page_reg[addr[15:14]], addr[13:0]};

    // in slot 0 the mapper sits behind sub-slot 3, minus the ffff register
    assign hit = (pri_slot == mapper_slot) &&
                 ((mapper0_en && exp_slot3_num[3] && !xffff) || mapper123_en);

    assign mem_read  = rfsh_n && !mreq_n && !rd_n && hit;
    assign mem_write = !mreq_n && !wr_n && hit;

    a_rw_exclusive: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        !(mem_read && mem_write));

endmodule

`default_nettype wire

//--- logic/config_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "msx_config.svh"

module config_regs (
    input  wire                     clk_108m,
    input  wire                     bus_reset_n,
    input  wire msx_pkg::cpu_addr_t addr,
    input  wire msx_pkg::bus_byte_t cpu_dout,
    input  wire                     m1_n,
    input  wire                     iorq_n,
    input  wire                     rd_n,
    input  wire                     wr_n,
    output logic                    cfg_read,
    output msx_pkg::bus_byte_t      cfg_dout,
    output msx_pkg::slot_t          mapper_slot,
    output logic                    mapper0_en,
    output logic                    mapper123_en
);

    msx_pkg::bus_byte_t config0;
    msx_pkg::bus_byte_t config1;
    logic               io_wr;
    logic               unlocked;

    assign io_wr    = !iorq_n && m1_n && !wr_n;
    assign unlocked = (config0 == `MSX_CFG_UNLOCK);

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            config0      <= 8'h00;
            config1      <= `MSX_CFG1_DEFAULT;
            mapper_slot  <= 2'b00;
            mapper0_en   <= 1'b1;
            mapper123_en <= 1'b0;
        end else if (io_wr) begin
            // key is written inverted
            if (addr[7:0] == `MSX_PORT_CFG0) begin
                config0 <= ~cpu_dout;
            end
            if (unlocked && addr[7:0] == `MSX_PORT_CFG1) begin
                config1 <= cpu_dout;
            end
            if (unlocked && addr[7:0] == `MSX_PORT_CFG2) begin
                // bit 7 applies the config1 mapper settings
                if (cpu_dout[7]) begin
                    mapper_slot  <= config1[5:4];
                    mapper0_en   <= config1[0] && (config1[5:4] == 2'b00);
                    mapper123_en <= config1[0] && (config1[5:4] != 2'b00);
                end
            end
        end
    end

    // readback on any 4x port
    assign cfg_read = (addr[7:4] == `MSX_CFG_READ_NIBBLE) && !iorq_n && m1_n && !rd_n;
    assign cfg_dout = (addr[3:0] == 4'h0) ? config0 :
                      (addr[3:0] == 4'h1) ? config1 : 8'hFF;

endmodule

`default_nettype wire

//--- logic/slot_select.sv
`timescale 1ns/10ps
`default_nettype none
`include "msx_config.svh"

module slot_select (
    input  wire                     clk_108m,
    input  wire                     bus_reset_n,
    input  wire msx_pkg::cpu_addr_t addr,
    input  wire msx_pkg::bus_byte_t cpu_dout,
    input  wire                     m1_n,
    input  wire                     mreq_n,
    input  wire                     iorq_n,
    input  wire                     wr_n,
    output msx_pkg::slot_t          pri_slot,
    output msx_pkg::onehot4_t       pri_slot_num,
    output msx_pkg::onehot4_t       exp_slot3_num,
    output msx_pkg::bus_byte_t      exp_slot3_reg,
    output logic                    xffff
);

    msx_pkg::bus_byte_t ppi_reg;
    msx_pkg::slot_t     exp_page_slot;
    logic               ppi_wr;
    logic               exp_wr;

    // --------------------------------------------------
    // register writes
    // --------------------------------------------------
    assign ppi_wr = (addr[7:0] == `MSX_PORT_PPI_A) && !iorq_n && m1_n && !wr_n;
    // xffff lags the address by a cycle
    assign exp_wr = !mreq_n && !wr_n && xffff && pri_slot_num[0];

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            ppi_reg       <= 8'h00;
            exp_slot3_reg <= 8'h00;
            xffff         <= 1'b0;
        end else begin
            xffff <= (addr == 16'hFFFF);
            if (ppi_wr) begin
                ppi_reg <= cpu_dout;
            end
            if (exp_wr) begin
                exp_slot3_reg <= cpu_dout;
            end
        end
    end

    // --------------------------------------------------
    // per-page decode
    // --------------------------------------------------
    // two bits per page, page 0 in the low bits
    assign pri_slot      = ppi_reg[{addr[15:14], 1'b0} +: 2];
    assign exp_page_slot = exp_slot3_reg[{addr[15:14], 1'b0} +: 2];

    assign pri_slot_num  = 4'b0001 << pri_slot;
    assign exp_slot3_num = 4'b0001 << exp_page_slot;

    // registered ffff flag, the address has to hold through the write
    a_exp_wr_addr: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        exp_wr |-> (addr == 16'hFFFF));

endmodule

`default_nettype wire

//--- logic/addr_demux.sv
`timescale 1ns/10ps
`default_nettype none
`include "msx_config.svh"

module addr_demux (
    input  wire                     clk_108m,
    input  wire                     bus_reset_n,
    input  wire msx_pkg::cpu_addr_t addr,
    input  wire                     update_addr,
    output logic [1:0]              msel,
    output msx_pkg::bus_byte_t      bus_mp
);

    // --------------------------------------------------
    // strobe schedule, counted from LATCH entry
    // --------------------------------------------------
    localparam logic [3:0] T_HI_ON  = 4'd1;
    localparam logic [3:0] T_HI_OFF = T_HI_ON + `MSX_DEMUX_TON;
    localparam logic [3:0] T_LO_SEL = T_HI_OFF + `MSX_DEMUX_TP;
    localparam logic [3:0] T_LO_ON  = T_LO_SEL + `MSX_DEMUX_TP;
    localparam logic [3:0] T_LO_OFF = T_LO_ON + `MSX_DEMUX_TON;

    msx_pkg::demux_state_t state;
    logic [3:0]            count;
    logic                  low_byte;

    // high byte until the low byte is selected
    assign bus_mp = low_byte ? addr[7:0] : addr[15:8];

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            state    <= msx_pkg::DEMUX_IDLE;
            count    <= 4'd0;
            low_byte <= 1'b0;
            msel     <= 2'b00;
        end else begin
            case (state)
                msx_pkg::DEMUX_IDLE: begin
                    count    <= 4'd0;
                    low_byte <= 1'b0;
                    msel     <= 2'b00;
                    if (update_addr) begin
                        state <= msx_pkg::DEMUX_LATCH;
                    end
                end
                msx_pkg::DEMUX_LATCH: begin
                    count <= count + 4'd1;
                    case (count)
                        T_HI_ON:  msel[1] <= 1'b1;
                        T_HI_OFF: msel[1] <= 1'b0;
                        T_LO_SEL: low_byte <= 1'b1;
                        T_LO_ON:  msel[0] <= 1'b1;
                        T_LO_OFF: begin
                            msel[0] <= 1'b0;
                            state   <= msx_pkg::DEMUX_FINISH;
                        end
                        default: ;
                    endcase
                end
                // hold the low byte until the cpu drops update_addr
                msx_pkg::DEMUX_FINISH: begin
                    if (!update_addr) begin
                        state <= msx_pkg::DEMUX_IDLE;
                    end
                end
                default: state <= msx_pkg::DEMUX_IDLE;
            endcase
        end
    end

    // both latches strobed at once would corrupt the external address
    a_msel_exclusive: assert property (
        @(posedge clk_108m) disable iff (!bus_reset_n) msel != 2'b11);

endmodule

`default_nettype wire

//--- logic/msx_pkg.sv
`default_nettype none

package msx_pkg;

    // z80 side
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  bus_byte_t;

    // slot decode
    typedef logic [1:0] slot_t;
    typedef logic [3:0] onehot4_t;

    // 8-bit page number followed by 14-bit offset
    typedef logic [21:0] mapper_addr_t;

    typedef enum logic [1:0] {
        DEMUX_IDLE   = 2'd0,
        DEMUX_LATCH  = 2'd1,
        DEMUX_FINISH = 2'd2
    } demux_state_t;

    // rd/wr delay machine
    typedef enum logic [1:0] {
        ISO_IDLE   = 2'd0,
        ISO_ACTIVE = 2'd1,
        ISO_WAIT   = 2'd2
    } iso_state_t;

endpackage

`default_nettype wire

//--- logic/msx_config.svh
`ifndef MSX_CONFIG_SVH
`define MSX_CONFIG_SVH

// --------------------------------------------------
// i/o port map
// --------------------------------------------------
// ppi port a, primary slot register
`define MSX_PORT_PPI_A        8'hA8
// fc..ff, only the upper six bits are decoded
`define MSX_PORT_MAPPER_BASE  6'h3F
`define MSX_PORT_CFG0         8'h40
`define MSX_PORT_CFG1         8'h41
`define MSX_PORT_CFG2         8'h42
// any 4x read hits the config block
`define MSX_CFG_READ_NIBBLE   4'h4

// --------------------------------------------------
// config block
// --------------------------------------------------
// config0 holds the inverted key
`define MSX_CFG_UNLOCK        8'hB7
`define MSX_CFG1_DEFAULT      8'h0B
`define MSX_CFG2_DEFAULT      8'h07

// mapper pages after reset
`define MSX_MAPPER_RESET0     8'h03
`define MSX_MAPPER_RESET1     8'h02
`define MSX_MAPPER_RESET2     8'h01
`define MSX_MAPPER_RESET3     8'h00

// --------------------------------------------------
// timing, in clk_108m cycles
// --------------------------------------------------
`define MSX_DEMUX_TON         4'd3
`define MSX_DEMUX_TP          4'd1
`define MSX_ISO_DELAY         3'd2

`endif
